//--- Bender.yml
package:
  name: apb_soc_ctrl

sources:
  - include_dirs:
      - .
    files:
      - soc_ctrl_bus_pkg.sv
      - soc_ctrl_cfg_pkg.sv
      - apb_slave_port.sv
      - pad_ctrl_regs.sv
      - boot_cluster_regs.sv
      - soc_status_regs.sv
      - apb_soc_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - soc_ctrl_checker.sv
      - tb_apb_soc_ctrl.sv

//--- apb_slave_port.sv
`timescale 1ns/1ps

`include "soc_ctrl_macros.svh"

module apb_slave_port
   import soc_ctrl_bus_pkg::*;
(
   input  logic        HCLK,
   input  logic        HRESETn,

   input  apb_req_t    apb_req_i,
   output apb_rsp_t    apb_rsp_o,

   output reg_access_t acc_o,

   input  logic [31:0] pad_rdata_i,
   input  logic [31:0] boot_rdata_i,
   input  logic [31:0] status_rdata_i
);

   logic access_phase;   // psel and penable both high

   assign access_phase = apb_req_i.psel & apb_req_i.penable;

   assign acc_o.wr    = access_phase & apb_req_i.pwrite;
   assign acc_o.idx   = apb_req_i.paddr[8:2];  // word index
   assign acc_o.wdata = apb_req_i.pwdata;

   // unselected blocks return zero
   assign apb_rsp_o.prdata  = pad_rdata_i | boot_rdata_i | status_rdata_i;
   assign apb_rsp_o.pready  = 1'b1;  // zero wait states
   assign apb_rsp_o.pslverr = 1'b0;

endmodule

//--- apb_soc_ctrl.sv
`timescale 1ns/1ps

`include "soc_ctrl_macros.svh"

module apb_soc_ctrl
   import soc_ctrl_bus_pkg::*;
   import soc_ctrl_cfg_pkg::*;
(
   input  logic                       HCLK,
   input  logic                       HRESETn,

   // APB slave
   input  apb_req_t                   apb_req_i,
   output apb_rsp_t                   apb_rsp_o,

   // JTAG exchange
   input  logic [`SOC_JTAG_W-1:0]     jtag_i,
   output logic [`SOC_JTAG_W-1:0]     jtag_o,

   // pads
   output pad_mux_t [`SOC_N_PADS-1:0] pad_mux_o,
   output pad_cfg_t [`SOC_N_PADS-1:0] pad_cfg_o,

   // boot and cluster control
   output fc_boot_t                   fc_boot_o,
   output cluster_ctrl_t              cluster_ctrl_o
);

   reg_access_t acc;           // shared by all blocks
   logic [31:0] pad_rdata;
   logic [31:0] boot_rdata;
   logic [31:0] status_rdata;

   apb_slave_port i_apb_slave_port
   (
      .HCLK           ( HCLK         ),
      .HRESETn        ( HRESETn      ),
      .apb_req_i      ( apb_req_i    ),
      .apb_rsp_o      ( apb_rsp_o    ),
      .acc_o          ( acc          ),
      .pad_rdata_i    ( pad_rdata    ),
      .boot_rdata_i   ( boot_rdata   ),
      .status_rdata_i ( status_rdata )
   );

   pad_ctrl_regs i_pad_ctrl_regs
   (
      .HCLK      ( HCLK      ),
      .HRESETn   ( HRESETn   ),
      .acc_i     ( acc       ),
      .rdata_o   ( pad_rdata ),
      .pad_mux_o ( pad_mux_o ),
      .pad_cfg_o ( pad_cfg_o )
   );

   boot_cluster_regs i_boot_cluster_regs
   (
      .HCLK           ( HCLK           ),
      .HRESETn        ( HRESETn        ),
      .acc_i          ( acc            ),
      .rdata_o        ( boot_rdata     ),
      .fc_boot_o      ( fc_boot_o      ),
      .cluster_ctrl_o ( cluster_ctrl_o )
   );

   soc_status_regs i_soc_status_regs
   (
      .HCLK    ( HCLK         ),
      .HRESETn ( HRESETn      ),
      .acc_i   ( acc          ),
      .rdata_o ( status_rdata ),
      .jtag_i  ( jtag_i       ),
      .jtag_o  ( jtag_o       )
   );

endmodule

//--- boot_cluster_regs.sv
`timescale 1ns/1ps

`include "soc_ctrl_macros.svh"

module boot_cluster_regs
   import soc_ctrl_bus_pkg::*;
   import soc_ctrl_cfg_pkg::*;
(
   input  logic          HCLK,
   input  logic          HRESETn,

   input  reg_access_t   acc_i,
   output logic [31:0]   rdata_o,

   output fc_boot_t      fc_boot_o,
   output cluster_ctrl_t cluster_ctrl_o
);

   fc_boot_t      fc_boot_q;
   cluster_ctrl_t cluster_ctrl_q;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         fc_boot_q.boot_addr     <= `SOC_FC_BOOT_RST;
         fc_boot_q.fetch_en      <= 1'b1;   // fc starts on its own
         cluster_ctrl_q.byp      <= 1'b1;
         cluster_ctrl_q.pow      <= 1'b0;
         cluster_ctrl_q.fetch_en <= 1'b0;
         cluster_ctrl_q.rstn     <= 1'b1;
      end
      else if (acc_i.wr)
      begin
         case (acc_i.idx)
            REG_FCBOOT:
            begin
               fc_boot_q.boot_addr <= acc_i.wdata;
            end
            REG_FCFETCH:
            begin
               fc_boot_q.fetch_en <= acc_i.wdata[0];
            end
            REG_CLUSTER_CTRL:
            begin
               cluster_ctrl_q <= cluster_ctrl_t'(acc_i.wdata[CLUSTER_CTRL_W-1:0]);
            end
            default:
            begin
               // not ours
            end
         endcase
      end
   end

   always_comb
   begin
      case (acc_i.idx)
         REG_FCBOOT:       rdata_o = fc_boot_q.boot_addr;
         REG_CLUSTER_CTRL: rdata_o = 32'(cluster_ctrl_q);  // zeros above bit 3
         default:          rdata_o = '0;  // FCFETCH is write only
      endcase
   end

   assign fc_boot_o      = fc_boot_q;
   assign cluster_ctrl_o = cluster_ctrl_q;

endmodule

//--- list.f
+incdir+.
soc_ctrl_bus_pkg.sv
soc_ctrl_cfg_pkg.sv
apb_slave_port.sv
pad_ctrl_regs.sv
boot_cluster_regs.sv
soc_status_regs.sv
apb_soc_ctrl.sv
soc_ctrl_checker.sv
tb_apb_soc_ctrl.sv

//--- pad_ctrl_regs.sv
`timescale 1ns/1ps

`include "soc_ctrl_macros.svh"

module pad_ctrl_regs
   import soc_ctrl_bus_pkg::*;
   import soc_ctrl_cfg_pkg::*;
(
   input  logic                          HCLK,
   input  logic                          HRESETn,

   input  reg_access_t                   acc_i,
   output logic [31:0]                   rdata_o,

   output pad_mux_t [`SOC_N_PADS-1:0]    pad_mux_o,
   output pad_cfg_t [`SOC_N_PADS-1:0]    pad_cfg_o
);

   localparam int unsigned MUX_PER_WORD = 32 / `SOC_PAD_MUX_W;   // 16 pads
   localparam int unsigned CFG_PER_WORD = 32 / PAD_CFG_LANE_W;    // 4 pads

   pad_mux_t [`SOC_N_PADS-1:0] pad_mux_q;
   pad_cfg_t [`SOC_N_PADS-1:0] pad_cfg_q;

   logic       fun_hit;
   logic       cfg_hit;
   logic [1:0] fun_word;  // PADFUN0..3
   logic [3:0] cfg_word;  // PADCFG0..15

   assign fun_hit  = (acc_i.idx >= REG_PADFUN0) && (acc_i.idx <= REG_PADFUN3);
   assign cfg_hit  = (acc_i.idx >= REG_PADCFG0) && (acc_i.idx <= REG_PADCFG15);
   assign fun_word = 2'(acc_i.idx - REG_PADFUN0);
   assign cfg_word = 4'(acc_i.idx - REG_PADCFG0);

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         pad_mux_q <= '0;
         pad_cfg_q <= {`SOC_N_PADS{pad_cfg_t'(`SOC_PAD_CFG_RST)}};
      end
      else if (acc_i.wr)
      begin
         if (fun_hit)
         begin
            // bit pair k selects pad 16n+k
            for (int k = 0; k < MUX_PER_WORD; k++)
            begin
               pad_mux_q[fun_word*MUX_PER_WORD + k] <=
                  acc_i.wdata[k*`SOC_PAD_MUX_W +: `SOC_PAD_MUX_W];
            end
         end
         else if (cfg_hit)
         begin
            // lane j configures pad 4n+j, top lane bits dropped
            for (int j = 0; j < CFG_PER_WORD; j++)
            begin
               pad_cfg_q[cfg_word*CFG_PER_WORD + j] <=
                  acc_i.wdata[j*PAD_CFG_LANE_W +: `SOC_PAD_CFG_W];
            end
         end
      end
   end

   always_comb
   begin
      rdata_o = '0;
      if (fun_hit)
      begin
         for (int k = 0; k < MUX_PER_WORD; k++)
         begin
            rdata_o[k*`SOC_PAD_MUX_W +: `SOC_PAD_MUX_W] = pad_mux_q[fun_word*MUX_PER_WORD + k];
         end
      end
      else if (cfg_hit)
      begin
         for (int j = 0; j < CFG_PER_WORD; j++)
         begin
            rdata_o[j*PAD_CFG_LANE_W +: PAD_CFG_LANE_W] =
               PAD_CFG_LANE_W'(pad_cfg_q[cfg_word*CFG_PER_WORD + j]);  // upper bits zero
         end
      end
   end

   assign pad_mux_o = pad_mux_q;
   assign pad_cfg_o = pad_cfg_q;

endmodule

//--- soc_ctrl_bus_pkg.sv
`include "soc_ctrl_macros.svh"

package soc_ctrl_bus_pkg;

   // APB master side
   typedef struct packed {
      logic [`SOC_APB_ADDR_W-1:0] paddr;
      logic [31:0]                pwdata;
      logic                       pwrite;
      logic                       psel;
      logic                       penable;
   } apb_req_t;

   // APB slave side
   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   // word index, taken from paddr[8:2]
   typedef enum logic [6:0] {
      REG_INFO         = 7'd0,
      REG_FCBOOT       = 7'd1,
      REG_FCFETCH      = 7'd2,
      REG_PADFUN0      = 7'd4,
      REG_PADFUN1      = 7'd5,
      REG_PADFUN2      = 7'd6,
      REG_PADFUN3      = 7'd7,
      REG_PADCFG0      = 7'd8,
      REG_PADCFG1      = 7'd9,
      REG_PADCFG2      = 7'd10,
      REG_PADCFG3      = 7'd11,
      REG_PADCFG4      = 7'd12,
      REG_PADCFG5      = 7'd13,
      REG_PADCFG6      = 7'd14,
      REG_PADCFG7      = 7'd15,
      REG_PADCFG8      = 7'd16,
      REG_PADCFG9      = 7'd17,
      REG_PADCFG10     = 7'd18,
      REG_PADCFG11     = 7'd19,
      REG_PADCFG12     = 7'd20,
      REG_PADCFG13     = 7'd21,
      REG_PADCFG14     = 7'd22,
      REG_PADCFG15     = 7'd23,
      REG_CLUSTER_CTRL = 7'd28,
      REG_JTAGREG      = 7'd29,
      REG_CORESTATUS   = 7'd40,
      REG_CS_RO        = 7'd48
   } soc_reg_e;

   // access broadcast to every register block
   typedef struct packed {
      logic                         wr;    // one cycle write strobe
      logic [$bits(soc_reg_e)-1:0] idx;   // raw index, may be unmapped
      logic [31:0]                  wdata;
   } reg_access_t;

endpackage

//--- soc_ctrl_cfg_pkg.sv
`include "soc_ctrl_macros.svh"

package soc_ctrl_cfg_pkg;

   // electrical setup of one pad, pull_up in bit 0
   typedef struct packed {
      logic [`SOC_PAD_CFG_W-5:0] drive;       // drive strength
      logic                      slew_limit;
      logic                      schmitt;
      logic                      pull_down;
      logic                      pull_up;
   } pad_cfg_t;

   // alternate function of one pad
   typedef logic [`SOC_PAD_MUX_W-1:0] pad_mux_t;

   // cluster control, byp in bit 0
   typedef struct packed {
      logic rstn;       // cluster reset, active low
      logic fetch_en;
      logic pow;        // power switch
      logic byp;        // clock bypass
   } cluster_ctrl_t;

   // fabric controller start-up
   typedef struct packed {
      logic [31:0] boot_addr;
      logic        fetch_en;
   } fc_boot_t;

   // Cluster control bits sit in the low nibble of CLUSTER_CTRL; the rest
   // of the word reads as zero. Pad configuration uses the lower six bits
   // of each 8-bit lane.
   localparam int unsigned CLUSTER_CTRL_W = $bits(cluster_ctrl_t);
   localparam int unsigned PAD_CFG_LANE_W = 8;

endpackage

//--- soc_ctrl_checker.sv
`timescale 1ns/1ps

`include "soc_ctrl_macros.svh"

module soc_ctrl_checker
   import soc_ctrl_bus_pkg::*;
   import soc_ctrl_cfg_pkg::*;
(
   input  logic                          HCLK,

   // DUT ports under watch
   input  apb_req_t                      apb_req_i,
   input  apb_rsp_t                      apb_rsp_i,
   input  pad_mux_t [`SOC_N_PADS-1:0]    pad_mux_i,
   input  pad_cfg_t [`SOC_N_PADS-1:0]    pad_cfg_i,
   input  fc_boot_t                      fc_boot_i,
   input  cluster_ctrl_t                 cluster_ctrl_i,
   input  logic [`SOC_JTAG_W-1:0]        dut_jtag_i,

   // compare requests from the testbench
   input  logic                          rd_chk_i,
   input  logic                          out_chk_i,
   input  logic [2:0]                    out_sel_i,
   input  logic [5:0]                    out_pad_i,
   input  logic [31:0]                   exp_i,

   output int                            err_cnt_o,
   output int                            chk_cnt_o
);

   int err_cnt = 0;
   int chk_cnt = 0;

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   always @(posedge HCLK)
   begin
      if (rd_chk_i)
      begin
         if (!(apb_req_i.psel && apb_req_i.penable))
         begin
            err_cnt++;
            $display("read compare requested outside an APB access phase");
         end
         compare("prdata", apb_rsp_i.prdata, exp_i);
         compare("pready", 32'(apb_rsp_i.pready), 32'h1);   // zero wait states
         compare("pslverr", 32'(apb_rsp_i.pslverr), 32'h0);
      end
      if (out_chk_i)
      begin
         case (out_sel_i)
            3'd0: compare($sformatf("pad_mux_o[%0d]", out_pad_i), 32'(pad_mux_i[out_pad_i]), exp_i);
            3'd1: compare($sformatf("pad_cfg_o[%0d]", out_pad_i), 32'(pad_cfg_i[out_pad_i]), exp_i);
            3'd2: compare("fc_boot_o.boot_addr", fc_boot_i.boot_addr, exp_i);
            3'd3: compare("fc_boot_o.fetch_en", 32'(fc_boot_i.fetch_en), exp_i);
            3'd4: compare("cluster_ctrl_o", 32'(cluster_ctrl_i), exp_i);
            3'd5: compare("jtag_o", 32'(dut_jtag_i), exp_i);
            default:
            begin
               err_cnt++;
               $display("output check asked for unknown output select %0d", out_sel_i);
            end
         endcase
      end
   end

   assign err_cnt_o = err_cnt;
   assign chk_cnt_o = chk_cnt;

endmodule

//--- soc_ctrl_macros.svh
`ifndef SOC_CTRL_MACROS_SVH
`define SOC_CTRL_MACROS_SVH

// pad counts and field widths
`define SOC_N_PADS       64
`define SOC_PAD_CFG_W    6
`define SOC_PAD_MUX_W    2

// width of the JTAG exchange register
`define SOC_JTAG_W       8

// system size reported in the info word
`define SOC_NB_CORES     4
`define SOC_NB_CLUSTERS  1

// APB slave address width, 4 KB window
`define SOC_APB_ADDR_W   12

// reset values
`define SOC_FC_BOOT_RST  32'h1A00_0080
`define SOC_PAD_CFG_RST  6'h3F

`endif

//--- soc_ctrl_stim.txt
// op idx data expected, op 0 write, 1 read, 2 jtag drive, 3 output check, 4 random write, F end
// output check idx 0 pad_mux, 1 pad_cfg, 2 boot_addr, 3 fc fetch_en, 4 cluster_ctrl, 5 jtag_o
3 01 00       0000003F
3 01 3F       0000003F
3 02 00       1A000080
3 03 00       00000001
3 04 00       00000009
1 00 00000000 00040001
1 08 00000000 3F3F3F3F
1 1D 00000000 00000000
0 0A C5AA13FF 00000000
3 01 08       0000003F
3 01 0A       0000002A
3 01 0B       00000005
1 0A 00000000 052A133F
0 05 1BE4729C 00000000
3 00 11       00000003
3 00 1E       00000001
3 00 0F       00000000
1 05 00000000 1BE4729C
0 01 1C008000 00000000
3 02 00       1C008000
1 01 00000000 1C008000
0 02 00000000 00000000
3 03 00       00000000
1 02 00000000 00000000
0 1C FFFFFFF6 00000000
3 04 00       00000006
1 1C 00000000 00000006
0 28 DEADBEEF 00000000
1 30 00000000 DEADBEEF
0 30 12345678 00000000
1 30 00000000 DEADBEEF
0 1D 000000A5 00000000
3 05 00       000000A5
2 00 0000003C 00000000
1 1D 00000000 00003CA5
4 03 00000000 00000000
4 18 00000000 00000000
4 7F 00000000 00000000
1 03 00000000 00000000
1 7F 00000000 00000000
3 02 00       1C008000
3 04 00       00000006
3 05 00       000000A5
F 00 00000000 00000000

//--- soc_status_regs.sv
`timescale 1ns/1ps

`include "soc_ctrl_macros.svh"

module soc_status_regs
   import soc_ctrl_bus_pkg::*;
(
   input  logic                   HCLK,
   input  logic                   HRESETn,

   input  reg_access_t            acc_i,
   output logic [31:0]            rdata_o,

   input  logic [`SOC_JTAG_W-1:0] jtag_i,
   output logic [`SOC_JTAG_W-1:0] jtag_o
);

   logic [31:0]            corestatus_q;  // eoc in bit 31 by convention
   logic [`SOC_JTAG_W-1:0] jtag_out_q;
   logic [`SOC_JTAG_W-1:0] jtag_sync1_q;  // first stage, may go metastable
   logic [`SOC_JTAG_W-1:0] jtag_sync2_q;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         corestatus_q <= '0;
         jtag_out_q   <= '0;
         jtag_sync1_q <= '0;
         jtag_sync2_q <= '0;
      end
      else
      begin
         jtag_sync1_q <= jtag_i;
         jtag_sync2_q <= jtag_sync1_q;
         if (acc_i.wr && acc_i.idx == REG_CORESTATUS)
         begin
            corestatus_q <= acc_i.wdata;  // CS_RO writes fall through
         end
         if (acc_i.wr && acc_i.idx == REG_JTAGREG)
         begin
            jtag_out_q <= acc_i.wdata[`SOC_JTAG_W-1:0];
         end
      end
   end

   always_comb
   begin
      case (acc_i.idx)
         REG_INFO:       rdata_o = {16'(`SOC_NB_CORES), 16'(`SOC_NB_CLUSTERS)};
         REG_CORESTATUS: rdata_o = corestatus_q;
         REG_CS_RO:      rdata_o = corestatus_q;  // read only mirror
         REG_JTAGREG:    rdata_o = 32'({jtag_sync2_q, jtag_out_q});
         default:        rdata_o = '0;
      endcase
   end

   assign jtag_o = jtag_out_q;

endmodule

//--- tb_apb_soc_ctrl.sv
`timescale 1ns/1ps

`include "soc_ctrl_macros.svh"

module tb_apb_soc_ctrl
   import soc_ctrl_bus_pkg::*;
   import soc_ctrl_cfg_pkg::*;
();

   localparam int MAX_OPS = 256;
   localparam int T_HALF  = 50;   // 100 ns clock
   localparam int T_DRV   = 5;    // drive delay after the rising edge

   logic                       HCLK;
   logic                       HRESETn;
   apb_req_t                   apb_req;
   apb_rsp_t                   apb_rsp;
   logic [`SOC_JTAG_W-1:0]     jtag_in;
   logic [`SOC_JTAG_W-1:0]     jtag_out;
   pad_mux_t [`SOC_N_PADS-1:0] pad_mux;
   pad_cfg_t [`SOC_N_PADS-1:0] pad_cfg;
   fc_boot_t                   fc_boot;
   cluster_ctrl_t              cluster_ctrl;

   logic [31:0] stim_mem [0:4*MAX_OPS-1];  // op, idx, data, expected
   int          n_ops;
   logic        stim_loaded;
   int          tb_err;
   logic        rd_chk;
   logic        out_chk;
   logic [2:0]  out_sel;
   logic [5:0]  out_pad;
   logic [31:0] exp_val;
   int          err_cnt;
   int          chk_cnt;

   apb_soc_ctrl i_dut
   (
      .HCLK           ( HCLK         ),
      .HRESETn        ( HRESETn      ),
      .apb_req_i      ( apb_req      ),
      .apb_rsp_o      ( apb_rsp      ),
      .jtag_i         ( jtag_in      ),
      .jtag_o         ( jtag_out     ),
      .pad_mux_o      ( pad_mux      ),
      .pad_cfg_o      ( pad_cfg      ),
      .fc_boot_o      ( fc_boot      ),
      .cluster_ctrl_o ( cluster_ctrl )
   );

   soc_ctrl_checker i_checker
   (
      .HCLK           ( HCLK         ),
      .apb_req_i      ( apb_req      ),
      .apb_rsp_i      ( apb_rsp      ),
      .pad_mux_i      ( pad_mux      ),
      .pad_cfg_i      ( pad_cfg      ),
      .fc_boot_i      ( fc_boot      ),
      .cluster_ctrl_i ( cluster_ctrl ),
      .dut_jtag_i     ( jtag_out     ),
      .rd_chk_i       ( rd_chk       ),
      .out_chk_i      ( out_chk      ),
      .out_sel_i      ( out_sel      ),
      .out_pad_i      ( out_pad      ),
      .exp_i          ( exp_val      ),
      .err_cnt_o      ( err_cnt      ),
      .chk_cnt_o      ( chk_cnt      )
   );

   initial
   begin
      HCLK = 1'b0;
      forever #(T_HALF) HCLK = ~HCLK;
   end

   // one setup cycle, one access cycle
   task apb_access(input logic wr, input logic [6:0] idx, input logic [31:0] data,
                   input logic [31:0] exp);
      apb_req         = '0;
      apb_req.paddr   = {idx, 2'b00};   // word address
      apb_req.pwdata  = data;
      apb_req.pwrite  = wr;
      apb_req.psel    = 1'b1;
      @(posedge HCLK);
      #(T_DRV);
      apb_req.penable = 1'b1;
      rd_chk          = ~wr;
      exp_val         = exp;
      @(posedge HCLK);
      #(T_DRV);
      apb_req         = '0;
      rd_chk          = 1'b0;
   endtask

   task check_output(input logic [2:0] sel, input logic [5:0] pad, input logic [31:0] exp);
      out_chk = 1'b1;
      out_sel = sel;
      out_pad = pad;
      exp_val = exp;
      @(posedge HCLK);
      #(T_DRV);
      out_chk = 1'b0;
   endtask

   task drive_jtag(input logic [`SOC_JTAG_W-1:0] val);
      jtag_in = val;
      repeat (3) @(posedge HCLK);   // covers the two sync stages
      #(T_DRV);
   endtask

   initial
   begin
      logic [31:0] op_w;
      logic [31:0] idx_w;
      logic [31:0] data_w;
      logic [31:0] exp_w;
      int          total;

      void'($urandom(56074));
      HRESETn     = 1'b0;
      apb_req     = '0;
      jtag_in     = '0;
      rd_chk      = 1'b0;
      out_chk     = 1'b0;
      out_sel     = '0;
      out_pad     = '0;
      exp_val     = '0;
      tb_err      = 0;
      stim_loaded = 1'b0;

      $readmemh("soc_ctrl_stim.txt", stim_mem);
      n_ops = 0;
      while (n_ops < MAX_OPS && !$isunknown(stim_mem[4*n_ops]) && stim_mem[4*n_ops] != 32'hF)
      begin
         n_ops++;
      end
      stim_loaded = 1'b1;
      if (n_ops == 0)
      begin
         tb_err++;
         $display("no stimulus could be read from soc_ctrl_stim.txt");
      end

      repeat (8) @(posedge HCLK);
      #(T_DRV);
      HRESETn = 1'b1;

      for (int i = 0; i < n_ops; i++)
      begin
         op_w   = stim_mem[4*i];
         idx_w  = stim_mem[4*i+1];
         data_w = stim_mem[4*i+2];
         exp_w  = stim_mem[4*i+3];
         case (op_w)
            32'h0: apb_access(1'b1, idx_w[6:0], data_w, '0);
            32'h1: apb_access(1'b0, idx_w[6:0], data_w, exp_w);
            32'h2: drive_jtag(data_w[`SOC_JTAG_W-1:0]);
            32'h3: check_output(idx_w[2:0], data_w[5:0], exp_w);
            32'h4: apb_access(1'b1, idx_w[6:0], $urandom(), '0);  // unmapped filler
            default:
            begin
               tb_err++;
               $display("unknown operation %0h in stimulus record %0d", op_w, i);
            end
         endcase
      end

      repeat (2) @(posedge HCLK);
      total = err_cnt + tb_err;
      $display("checks %0d, errors %0d", chk_cnt, total);
      if (total == 0)
      begin
         $display("Simulation PASSED");
      end
      else
      begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // watchdog, sized from the stimulus length
   initial
   begin
      wait (stim_loaded === 1'b1);
      repeat (n_ops*6 + 8 + 50) @(posedge HCLK);
      $display("timeout: the stimulus did not finish within %0d cycles", n_ops*6 + 58);
      $display("Simulation FAILED");
      $finish;
   end

endmodule
